//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int NUM_SRC    = 2;   // rs and rt

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;

    // SPECIAL function field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        alu_op_e                          alu_op;
        logic [NUM_SRC-1:0][DATA_W-1:0]   operand;  // [0] rs side, [1] rt side
        logic [REG_ADDR_W-1:0]            dest;
        logic                             we;
        logic                             illegal;
    } issue_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] dest;
        logic                  we;
        logic [DATA_W-1:0]     data;
        logic                  illegal;
    } result_t;

endpackage

//--- verilog/inst_decoder.sv
`timescale 1ns/100ps
module inst_decoder import cpu_pkg::*; (
    input  logic [DATA_W-1:0]                  inst_i,
    output logic [NUM_SRC-1:0]                 rd_en_o,
    output logic [NUM_SRC-1:0][REG_ADDR_W-1:0] rd_addr_o,
    output logic [DATA_W-1:0]                  imm_o,
    output alu_op_e                            alu_op_o,
    output logic [REG_ADDR_W-1:0]              dest_o,
    output logic                               we_o,
    output logic                               illegal_o
);

    logic [5:0]            op;
    logic [5:0]            fn;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [DATA_W-1:0]     zext_imm;
    logic [DATA_W-1:0]     sext_imm;
    logic                  i_type;
    logic                  legal;

    assign op       = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign shamt    = inst_i[10:6];
    assign fn       = inst_i[5:0];
    assign zext_imm = {16'h0, inst_i[15:0]};
    assign sext_imm = {{16{inst_i[15]}}, inst_i[15:0]};

    always_comb begin
        rd_en_o      = '0;
        rd_addr_o[0] = rs;
        rd_addr_o[1] = rt;
        imm_o        = '0;
        alu_op_o     = ALU_NOP;
        dest_o       = rd;
        we_o         = 1'b0;
        legal        = 1'b0;
        i_type       = 1'b0;
        case (op)
            OP_SPECIAL: begin
                if (rs == '0 && (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA)) begin
                    // shamt goes in as source one
                    rd_en_o[1] = 1'b1;
                    imm_o      = DATA_W'(shamt);
                    alu_op_o   = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                    we_o       = 1'b1;
                    legal      = 1'b1;
                end else if (shamt == '0) begin
                    legal = 1'b1;
                    case (fn)
                        FN_OR:           alu_op_o = ALU_OR;
                        FN_AND:          alu_op_o = ALU_AND;
                        FN_XOR:          alu_op_o = ALU_XOR;
                        FN_NOR:          alu_op_o = ALU_NOR;
                        FN_SLLV:         alu_op_o = ALU_SLL;
                        FN_SRLV:         alu_op_o = ALU_SRL;
                        FN_SRAV:         alu_op_o = ALU_SRA;
                        FN_ADD, FN_ADDU: alu_op_o = ALU_ADD;  // no overflow trap
                        FN_SUB, FN_SUBU: alu_op_o = ALU_SUB;
                        FN_SLT:          alu_op_o = ALU_SLT;
                        FN_SLTU:         alu_op_o = ALU_SLTU;
                        default:         legal = 1'b0;        // mult, div, hi/lo, sync...
                    endcase
                    rd_en_o = {NUM_SRC{legal}};
                    we_o    = legal;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                alu_op_o = (op == OP_ORI) ? ALU_OR : (op == OP_ANDI) ? ALU_AND : ALU_XOR;
                imm_o    = zext_imm;
                i_type   = 1'b1;
            end
            OP_LUI: begin
                alu_op_o = ALU_OR;   // rs is r0, so or just passes imm
                imm_o    = {inst_i[15:0], 16'h0};
                i_type   = 1'b1;
            end
            OP_ADDI, OP_ADDIU: begin
                alu_op_o = ALU_ADD;
                imm_o    = sext_imm;
                i_type   = 1'b1;
            end
            OP_SLTI: begin
                alu_op_o = ALU_SLT;
                imm_o    = sext_imm;
                i_type   = 1'b1;
            end
            OP_SLTIU: begin
                alu_op_o = ALU_SLTU;
                imm_o    = sext_imm;   // sign extended, then compared unsigned
                i_type   = 1'b1;
            end
            default: begin
            end
        endcase
        if (i_type) begin
            rd_en_o[0] = 1'b1;
            dest_o     = rt;
            we_o       = 1'b1;
            legal      = 1'b1;
        end
        if (dest_o == '0) begin
            we_o = 1'b0;   // r0 is never written or forwarded
        end
        illegal_o = !legal;
    end

endmodule

//--- verilog/operand_fwd.sv
`timescale 1ns/100ps
module operand_fwd import cpu_pkg::*; (
    input  logic                  rd_en_i,
    input  logic [REG_ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0]     rf_data_i,
    input  logic [DATA_W-1:0]     imm_i,
    input  logic                  ex_valid_i,
    input  logic                  ex_we_i,
    input  logic [REG_ADDR_W-1:0] ex_addr_i,
    input  logic [DATA_W-1:0]     ex_data_i,
    input  logic                  wb_valid_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [DATA_W-1:0]     wb_data_i,
    output logic [DATA_W-1:0]     operand_o
);

    logic ex_hit;
    logic wb_hit;

    assign ex_hit = ex_valid_i && ex_we_i && (ex_addr_i == addr_i);
    assign wb_hit = wb_valid_i && wb_we_i && (wb_addr_i == addr_i);

    // newest producer wins
    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_data_i;
        end else if (wb_hit) begin
            operand_o = wb_data_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/100ps
module regfile import cpu_pkg::*; (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [NUM_SRC-1:0][REG_ADDR_W-1:0] rd_addr_i,
    output logic [NUM_SRC-1:0][DATA_W-1:0]     rd_data_o,
    input  logic                               wr_valid_i,
    input  logic                               wr_ready_i,
    input  logic                               wr_we_i,
    input  logic [REG_ADDR_W-1:0]              wr_addr_i,
    input  logic [DATA_W-1:0]                  wr_data_i
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_en;

    assign wr_en = wr_valid_i && wr_ready_i && wr_we_i;   // result beat accepted

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_SRC; p++) begin
            rd_data_o[p] = (rd_addr_i[p] == '0) ? '0 : regs[rd_addr_i[p]];
        end
    end

    // decoder drops the write flag for r0
    no_r0_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en |-> wr_addr_i != '0)
        else $error("write to r0 reached the register file");

endmodule

//--- verilog/pipe_stage.sv
`timescale 1ns/100ps
module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    assign in_ready_o  = !valid_q || out_ready_i;   // empty or draining
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_ready_o && in_valid_i) begin
            data_q <= in_data_i;
        end
    end

    // upstream holds its beat until taken
    hold_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
        else $error("stage input changed while stalled");

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps
module alu import cpu_pkg::*; (
    input  issue_t            op_i,
    output result_t           result_o,
    output logic [DATA_W-1:0] data_o
);

    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;
    logic [4:0]        sh;
    logic [DATA_W-1:0] res;

    assign src_a = op_i.operand[0];
    assign src_b = op_i.operand[1];
    assign sh    = src_a[4:0];   // shift amount from source one

    always_comb begin
        case (op_i.alu_op)
            ALU_OR:   res = src_a | src_b;
            ALU_AND:  res = src_a & src_b;
            ALU_XOR:  res = src_a ^ src_b;
            ALU_NOR:  res = ~(src_a | src_b);
            ALU_SLL:  res = src_b << sh;
            ALU_SRL:  res = src_b >> sh;
            ALU_SRA:  res = $unsigned($signed(src_b) >>> sh);
            ALU_ADD:  res = src_a + src_b;
            ALU_SUB:  res = src_a - src_b;
            ALU_SLT:  res = DATA_W'($signed(src_a) < $signed(src_b));
            ALU_SLTU: res = DATA_W'(src_a < src_b);
            default:  res = '0;   // nop and illegal
        endcase
    end

    assign data_o           = res;
    assign result_o.dest    = op_i.dest;
    assign result_o.we      = op_i.we;
    assign result_o.data    = res;
    assign result_o.illegal = op_i.illegal;

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/100ps
module cpu_core import cpu_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  inst_valid_i,
    input  logic [DATA_W-1:0]     inst_i,
    output logic                  inst_ready_o,
    output logic                  res_valid_o,
    output logic                  res_we_o,
    output logic [REG_ADDR_W-1:0] res_addr_o,
    output logic [DATA_W-1:0]     res_data_o,
    output logic                  res_illegal_o,
    input  logic                  res_ready_i
);

    logic [NUM_SRC-1:0]                 dec_rd_en;
    logic [NUM_SRC-1:0][REG_ADDR_W-1:0] dec_rd_addr;
    logic [DATA_W-1:0]                  dec_imm;
    alu_op_e                            dec_alu_op;
    logic [REG_ADDR_W-1:0]              dec_dest;
    logic                               dec_we;
    logic                               dec_illegal;
    logic [NUM_SRC-1:0][DATA_W-1:0]     rf_rd_data;
    logic [NUM_SRC-1:0][DATA_W-1:0]     src_op;
    issue_t                             issue_in;
    issue_t                             issue_q;
    logic                               issue_valid;
    logic                               res_stage_ready;
    result_t                            alu_res;
    logic [DATA_W-1:0]                  alu_data;
    result_t                            res_q;

    inst_decoder u_dec (
        .inst_i    (inst_i),
        .rd_en_o   (dec_rd_en),
        .rd_addr_o (dec_rd_addr),
        .imm_o     (dec_imm),
        .alu_op_o  (dec_alu_op),
        .dest_o    (dec_dest),
        .we_o      (dec_we),
        .illegal_o (dec_illegal)
    );

    regfile u_rf (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_addr_i  (dec_rd_addr),
        .rd_data_o  (rf_rd_data),
        .wr_valid_i (res_valid_o),
        .wr_ready_i (res_ready_i),
        .wr_we_i    (res_q.we),
        .wr_addr_i  (res_q.dest),
        .wr_data_i  (res_q.data)
    );

    // issue stage is the newer source, result stage the older
    for (genvar g = 0; g < NUM_SRC; g++) begin : g_fwd
        operand_fwd u_fwd (
            .rd_en_i    (dec_rd_en[g]),
            .addr_i     (dec_rd_addr[g]),
            .rf_data_i  (rf_rd_data[g]),
            .imm_i      (dec_imm),
            .ex_valid_i (issue_valid),
            .ex_we_i    (issue_q.we),
            .ex_addr_i  (issue_q.dest),
            .ex_data_i  (alu_data),
            .wb_valid_i (res_valid_o),
            .wb_we_i    (res_q.we),
            .wb_addr_i  (res_q.dest),
            .wb_data_i  (res_q.data),
            .operand_o  (src_op[g])
        );
    end

    assign issue_in = '{alu_op: dec_alu_op, operand: src_op, dest: dec_dest,
                        we: dec_we, illegal: dec_illegal};

    pipe_stage #(.payload_t(issue_t)) u_issue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (inst_valid_i),
        .in_ready_o  (inst_ready_o),
        .in_data_i   (issue_in),
        .out_valid_o (issue_valid),
        .out_ready_i (res_stage_ready),
        .out_data_o  (issue_q)
    );

    alu u_alu (
        .op_i     (issue_q),
        .result_o (alu_res),
        .data_o   (alu_data)
    );

    pipe_stage #(.payload_t(result_t)) u_result (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (issue_valid),
        .in_ready_o  (res_stage_ready),
        .in_data_i   (alu_res),
        .out_valid_o (res_valid_o),
        .out_ready_i (res_ready_i),
        .out_data_o  (res_q)
    );

    assign res_we_o      = res_q.we;
    assign res_addr_o    = res_q.dest;
    assign res_data_o    = res_q.data;
    assign res_illegal_o = res_q.illegal;

endmodule

//--- dv/tb_cpu_core.sv
`timescale 1ns/100ps
module tb_cpu_core import cpu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 5000;   // < 400 insts at up to 4 cycles each, plus drains
    localparam logic [5:0] FN_MULT = 6'b011000;
    localparam logic [5:0] OP_BAD  = 6'b111111;

    logic                  clk_i;
    logic                  rst_i;
    logic                  inst_valid_i;
    logic [DATA_W-1:0]     inst_i;
    logic                  inst_ready_o;
    logic                  res_valid_o;
    logic                  res_we_o;
    logic [REG_ADDR_W-1:0] res_addr_o;
    logic [DATA_W-1:0]     res_data_o;
    logic                  res_illegal_o;
    logic                  res_ready_i;

    logic [DATA_W-1:0] model [NUM_REGS];   // reference register file
    logic [31:0]       pend_q [$];         // accepted, result not yet seen
    int                acc_q [$];
    logic [31:0]       lfsr_q = 32'hbed0;
    int                cycle_cnt = 0;
    int                sent_cnt = 0;
    int                beat_cnt = 0;
    int                ill_cnt = 0;
    int                test_err = 0;
    int                err_total = 0;
    int                tests_run = 0;
    int                tests_ok = 0;
    logic              bp_mode = 1'b0;
    logic              lat_check = 1'b0;
    string             cur_test = "none";

    cpu_core DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_ready_o  (inst_ready_o),
        .res_valid_o   (res_valid_o),
        .res_we_o      (res_we_o),
        .res_addr_o    (res_addr_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o),
        .res_ready_i   (res_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];   // taps 32,22,2,1
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // expected beat from the MIPS rules and the model state
    task automatic ref_exec(input logic [31:0] w, output logic we, output logic [4:0] dest,
                            output logic [31:0] data, output logic ill);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zx;
        logic [31:0] sx;
        op   = w[31:26];
        fn   = w[5:0];
        sh   = w[10:6];
        a    = model[w[25:21]];
        b    = model[w[20:16]];
        zx   = {16'h0, w[15:0]};
        sx   = {{16{w[15]}}, w[15:0]};
        ill  = 1'b0;
        dest = w[15:11];
        data = '0;
        if (op == OP_SPECIAL) begin
            if (fn inside {FN_SLL, FN_SRL, FN_SRA}) begin
                ill = (w[25:21] != 5'd0);
                if (fn == FN_SLL) data = b << sh;
                else if (fn == FN_SRL) data = b >> sh;
                else data = 32'($signed(b) >>> sh);
            end else if (sh != 5'd0) begin
                ill = 1'b1;
            end else begin
                case (fn)
                    FN_OR:           data = a | b;
                    FN_AND:          data = a & b;
                    FN_XOR:          data = a ^ b;
                    FN_NOR:          data = ~(a | b);
                    FN_SLLV:         data = b << a[4:0];
                    FN_SRLV:         data = b >> a[4:0];
                    FN_SRAV:         data = 32'($signed(b) >>> a[4:0]);
                    FN_ADD, FN_ADDU: data = a + b;
                    FN_SUB, FN_SUBU: data = a - b;
                    FN_SLT:          data = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU:         data = {31'b0, a < b};
                    default:         ill = 1'b1;
                endcase
            end
        end else begin
            dest = w[20:16];
            case (op)
                OP_ORI:            data = a | zx;
                OP_ANDI:           data = a & zx;
                OP_XORI:           data = a ^ zx;
                OP_LUI:            data = {w[15:0], 16'h0};
                OP_ADDI, OP_ADDIU: data = a + sx;
                OP_SLTI:           data = {31'b0, $signed(a) < $signed(sx)};
                OP_SLTIU:          data = {31'b0, a < sx};
                default:           ill = 1'b1;
            endcase
        end
        we = !ill && dest != 5'd0;
    endtask

    task automatic check_beat();
        logic [31:0] w;
        int          acc;
        logic        e_we;
        logic [4:0]  e_dest;
        logic [31:0] e_data;
        logic        e_ill;
        beat_cnt++;
        if (res_illegal_o) ill_cnt++;
        if (pend_q.size() == 0) begin
            $display("Error: %s got a result beat with no instruction outstanding", cur_test);
            test_err++;
            return;
        end
        w   = pend_q.pop_front();
        acc = acc_q.pop_front();
        ref_exec(w, e_we, e_dest, e_data, e_ill);
        assert (res_illegal_o == e_ill) else begin
            $display("Error: %s illegal expected %b actual %b", cur_test, e_ill, res_illegal_o);
            test_err++;
        end
        assert (res_we_o == e_we) else begin
            $display("Error: %s we expected %b actual %b", cur_test, e_we, res_we_o);
            test_err++;
        end
        if (!e_ill) begin
            assert (res_addr_o == e_dest) else begin
                $display("Error: %s dest expected %0d actual %0d", cur_test, e_dest, res_addr_o);
                test_err++;
            end
            assert (res_data_o == e_data) else begin
                $display("Error: %s data expected %h actual %h", cur_test, e_data, res_data_o);
                test_err++;
            end
        end
        if (lat_check) begin
            assert (cycle_cnt - acc == 2) else begin
                $display("Error: %s latency expected 2 actual %0d", cur_test, cycle_cnt - acc);
                test_err++;
            end
        end
        if (e_we) model[e_dest] = e_data;
    endtask

    // everything sampled mid-cycle, well away from the drive edges
    always @(negedge clk_i) begin
        if (!rst_i && res_valid_o && res_ready_i) check_beat();
    end

    initial begin
        res_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #2;
            res_ready_i = bp_mode ? lfsr_bit() : 1'b1;
        end
    end

    task automatic send_inst(input logic [31:0] w);
        inst_valid_i = 1'b1;
        inst_i       = w;
        @(negedge clk_i);
        while (!inst_ready_o) @(negedge clk_i);
        pend_q.push_back(w);
        acc_q.push_back(cycle_cnt);
        sent_cnt++;
        @(posedge clk_i);
        #2;
        inst_valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic drain();
        do @(posedge clk_i); while (pend_q.size() != 0);
        #2;
        idle(3);
        assert (beat_cnt == sent_cnt) else begin
            $display("Error: %s result beats expected %0d actual %0d", cur_test, sent_cnt, beat_cnt);
            test_err++;
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_err == 0) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: FAIL, %0d errors", cur_test, test_err);
        end
        err_total += test_err;
        test_err = 0;
    endtask

    function automatic logic [5:0] stream_code(input int sel);
        case (sel)
            0:       return FN_OR;
            1:       return FN_AND;
            2:       return FN_XOR;
            3:       return FN_NOR;
            4:       return FN_SLLV;
            5:       return FN_SRLV;
            6:       return FN_SRAV;
            7:       return FN_ADD;
            8:       return FN_ADDU;
            9:       return FN_SUB;
            10:      return FN_SUBU;
            11:      return FN_SLT;
            12:      return FN_SLTU;
            13:      return FN_SLL;
            14:      return FN_SRL;
            15:      return FN_SRA;
            16:      return OP_ADDI;
            17:      return OP_ADDIU;
            18:      return OP_SLTI;
            default: return OP_SLTIU;
        endcase
    endfunction

    // rs reads the last dest (issue stage), rt the one before (result stage)
    task automatic dep_stream(input int n);
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic [4:0]  dst;
        logic [31:0] w;
        int          sel;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int k = 0; k < n; k++) begin
            dst = 5'd10 + 5'((k / 2) % 12);   // pairs share a dest so both stages match
            sel = k % 20;
            if (sel < 13) begin
                w = (k % 2 == 1) ? r_type(stream_code(sel), prev2, prev1, dst, 5'd0)
                                 : r_type(stream_code(sel), prev1, prev2, dst, 5'd0);
            end else if (sel < 16) begin
                w = r_type(stream_code(sel), 5'd0, prev1, dst, 5'(rand_bits(5)));
            end else begin
                w = i_type(stream_code(sel), prev1, dst, 16'(rand_bits(16)));
            end
            send_inst(w);
            prev2 = prev1;
            prev1 = dst;
        end
    endtask

    task automatic reset_state();
        cur_test = "reset_state";
        @(negedge clk_i);
        assert (res_valid_o == 1'b0) else begin
            $display("Error: %s res_valid_o expected 0 actual %b", cur_test, res_valid_o);
            test_err++;
        end
        assert (inst_ready_o == 1'b1) else begin
            $display("Error: %s inst_ready_o expected 1 actual %b", cur_test, inst_ready_o);
            test_err++;
        end
        @(posedge clk_i);
        #2;
        for (int r = 0; r < NUM_REGS; r++) begin
            send_inst(r_type(FN_OR, 5'(r), 5'd0, 5'(r), 5'd0));
        end
        drain();
        finish_test();
    endtask

    task automatic imm_loads();
        logic [31:0] v;
        cur_test = "imm_loads";
        for (int r = 1; r <= 8; r++) begin
            v = rand_bits(32);
            send_inst(i_type(OP_LUI, 5'd0, 5'(r), v[31:16]));
            send_inst(i_type(OP_ORI, 5'(r), 5'(r), v[15:0]));
        end
        for (int r = 1; r <= 8; r++) begin
            v = rand_bits(32);
            send_inst(i_type(OP_ANDI, 5'(r), 5'(r + 8), v[15:0]));
            send_inst(i_type(OP_XORI, 5'(r + 8), 5'(r + 8), v[31:16]));
        end
        drain();
        finish_test();
    endtask

    task automatic latency_test();
        cur_test  = "latency";
        lat_check = 1'b1;
        for (int k = 0; k < 6; k++) begin
            send_inst(i_type(OP_ADDIU, 5'(20 + k), 5'(21 + k), 16'(rand_bits(16))));
            idle(int'(rand_bits(2)));
        end
        dep_stream(6);
        drain();
        lat_check = 1'b0;
        finish_test();
    endtask

    task automatic illegal_test();
        int ill_start;
        cur_test  = "illegal";
        ill_start = ill_cnt;
        send_inst(r_type(FN_MULT, 5'd3, 5'd4, 5'd0, 5'd0));
        send_inst(i_type(OP_BAD, 5'd1, 5'd5, 16'h1234));
        for (int r = 1; r < 16; r++) begin
            send_inst(r_type(FN_OR, 5'(r), 5'd0, 5'(r), 5'd0));
        end
        drain();
        assert (ill_cnt - ill_start == 2) else begin
            $display("Error: %s illegal beats expected 2 actual %0d", cur_test, ill_cnt - ill_start);
            test_err++;
        end
        finish_test();
    endtask

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Error: run stopped at the limit of %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int r = 0; r < NUM_REGS; r++) model[r] = '0;
        repeat (3) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        reset_state();
        imm_loads();
        cur_test = "dep_stream";
        dep_stream(80);
        drain();
        finish_test();
        latency_test();
        cur_test = "backpressure";
        bp_mode  = 1'b1;
        dep_stream(60);
        drain();
        bp_mode = 1'b0;
        finish_test();
        illegal_test();
        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, err_total);
        if (err_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- project.f
verilog/cpu_pkg.sv
verilog/inst_decoder.sv
verilog/operand_fwd.sv
verilog/regfile.sv
verilog/pipe_stage.sv
verilog/alu.sv
verilog/cpu_core.sv
dv/tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, verdict comes from the log
verilator --binary --timing --assert -f project.f --top-module tb_cpu_core -o sim_cpu_core \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_cpu_core > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see sim.log"; exit 1; }
